/* src/ulpi_link.sv */
`timescale 1ns/1ps
module ulpi_link (
  input  logic                   ulpi_clk,
  input  logic                   rst_n,
  input  logic                   ulpi_dir_i,
  input  logic                   ulpi_nxt_i,
  input  logic [7:0]             ulpi_data_i,
  output logic [7:0]             ulpi_data_o,
  output logic                   ulpi_stp_o,
  output logic                   ulpi_reset_o,
  output logic                   rx_valid_o,
  output ulpi_pkg::stream_beat_t rx_beat_o,
  input  logic                   rx_ready_i,
  input  logic                   tx_valid_i,
  input  ulpi_pkg::stream_beat_t tx_beat_i,
  output logic                   tx_ready_o,
  output ulpi_pkg::usb_status_t  status_o,
  output logic                   idle_o
);
  import ulpi_pkg::*;

  ulpi_bus_t  bus;
  logic       dir_q;
  logic [7:0] tx_data;
  logic       tx_stp;
  logic       rx_stp_req;
  logic       rx_active_end;
  logic       overflow;
  logic       vbus_valid;
  logic [1:0] line_state;

  assign bus = '{dir: ulpi_dir_i, nxt: ulpi_nxt_i, data: ulpi_data_i};

  // Previous dir marks the turnaround cycle
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      dir_q <= 1'b0;
    end else begin
      dir_q <= ulpi_dir_i;
    end
  end

  assign ulpi_data_o  = (!dir_q && !ulpi_dir_i) ? tx_data : 8'h00;
  assign ulpi_stp_o   = tx_stp | rx_stp_req;
  assign ulpi_reset_o = ~rst_n;
  assign status_o     = '{line_state: line_state, vbus_valid: vbus_valid,
                          rx_overflow: overflow};

  ulpi_rx_cmd u_rx_cmd (
    .ulpi_clk        (ulpi_clk),
    .rst_n           (rst_n),
    .bus_i           (bus),
    .dir_q_i         (dir_q),
    .line_state_o    (line_state),
    .vbus_valid_o    (vbus_valid),
    .rx_active_end_o (rx_active_end)
  );

  ulpi_rx_capture u_rx_capture (
    .ulpi_clk        (ulpi_clk),
    .rst_n           (rst_n),
    .bus_i           (bus),
    .dir_q_i         (dir_q),
    .rx_active_end_i (rx_active_end),
    .rx_ready_i      (rx_ready_i),
    .rx_valid_o      (rx_valid_o),
    .rx_beat_o       (rx_beat_o),
    .overflow_o      (overflow),
    .stp_req_o       (rx_stp_req)
  );

  ulpi_tx_ctrl u_tx_ctrl (
    .ulpi_clk   (ulpi_clk),
    .rst_n      (rst_n),
    .bus_i      (bus),
    .dir_q_i    (dir_q),
    .tx_valid_i (tx_valid_i),
    .tx_beat_i  (tx_beat_i),
    .tx_ready_o (tx_ready_o),
    .data_o     (tx_data),
    .stp_o      (tx_stp),
    .idle_o     (idle_o)
  );

endmodule

/* src/ulpi_pkg.sv */
package ulpi_pkg;

  // What the PHY drives into the link
  typedef struct packed {
    logic       dir;
    logic       nxt;
    logic [7:0] data;
  } ulpi_bus_t;

  typedef struct packed {
    logic [1:0] line_state;
    logic       vbus_valid;
    logic       rx_overflow;  // Sticky until reset
  } usb_status_t;

  // One byte of the RX or TX stream
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } stream_beat_t;

  typedef enum logic [2:0] {
    LS_INIT,
    LS_WRITE_ADDR,
    LS_WRITE_DATA,
    LS_STOP,
    LS_IDLE,
    LS_TX,
    LS_TX_LAST
  } link_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_TURN,
    RX_RECV,
    RX_DONE
  } rx_state_e;

  // Upper two bits of a link command byte
  typedef enum logic [1:0] {
    CMD_IDLE      = 2'b00,
    CMD_TX        = 2'b01,
    CMD_REG_WRITE = 2'b10
  } ulpi_cmd_e;

  localparam logic [5:0] REG_OTG_CTRL  = 6'h0A;
  localparam logic [5:0] REG_FUNC_CTRL = 6'h04;
  localparam logic [7:0] OTG_CTRL_INIT = 8'h00;
  localparam logic [7:0] FUNC_CTRL_FS  = 8'h45;  // FS xcvr, FS term, normal op
  localparam logic [1:0] RXCMD_ACTIVE  = 2'b01;
  localparam logic [1:0] LINE_SE0      = 2'b00;

endpackage

/* src/ulpi_rx_capture.sv */
`timescale 1ns/1ps
module ulpi_rx_capture (
  input  logic                   ulpi_clk,
  input  logic                   rst_n,
  input  ulpi_pkg::ulpi_bus_t    bus_i,
  input  logic                   dir_q_i,
  input  logic                   rx_active_end_i,
  input  logic                   rx_ready_i,
  output logic                   rx_valid_o,
  output ulpi_pkg::stream_beat_t rx_beat_o,
  output logic                   overflow_o,
  output logic                   stp_req_o
);
  import ulpi_pkg::*;

  rx_state_e  state_q;
  logic [7:0] dat_q;
  logic       load;
  logic       rx_end;
  logic       emit;
  logic       emit_last;

  assign load   = dir_q_i && bus_i.dir && bus_i.nxt;  // Packet byte from PHY
  assign rx_end = !bus_i.dir || rx_active_end_i;

  // Held byte goes out when the next one arrives or the packet ends
  assign emit      = (state_q == RX_RECV) && (load || rx_end);
  assign emit_last = emit && !load;

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      state_q    <= RX_IDLE;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= emit;
      case (state_q)
        RX_IDLE: begin
          if (!dir_q_i && bus_i.dir && bus_i.nxt) begin
            state_q <= RX_TURN;  // Turnaround with RxActive
          end else if (dir_q_i && bus_i.dir && !bus_i.nxt &&
                       bus_i.data[5:4] == RXCMD_ACTIVE) begin
            state_q <= RX_TURN;  // RxActive from an RX command
          end
        end
        RX_TURN: begin
          if (load) begin
            state_q <= RX_RECV;  // First byte is the PID
          end else if (rx_end) begin
            state_q <= RX_IDLE;
          end
        end
        RX_RECV: begin
          if (emit_last) begin
            state_q <= RX_DONE;
          end
        end
        default: state_q <= RX_IDLE;  // One dead cycle after a packet
      endcase
    end
  end

  // Delay register one byte behind the PHY
  always_ff @(posedge ulpi_clk) begin
    if (load) begin
      dat_q <= bus_i.data;
    end
    if (emit) begin
      rx_beat_o.data <= dat_q;
      rx_beat_o.last <= emit_last;
    end
  end

  // The PHY cannot be stalled, so a refused beat is dropped
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      overflow_o <= 1'b0;
      stp_req_o  <= 1'b0;
    end else begin
      if (rx_valid_o && !rx_ready_i) begin
        overflow_o <= 1'b1;
      end
      stp_req_o <= dir_q_i && bus_i.dir && !rx_ready_i;  // Ask PHY to abort
    end
  end

endmodule

/* src/ulpi_rx_cmd.sv */
`timescale 1ns/1ps
module ulpi_rx_cmd (
  input  logic                ulpi_clk,
  input  logic                rst_n,
  input  ulpi_pkg::ulpi_bus_t bus_i,
  input  logic                dir_q_i,
  output logic [1:0]          line_state_o,
  output logic                vbus_valid_o,
  output logic                rx_active_end_o
);
  import ulpi_pkg::*;

  logic rx_cmd;

  // PHY owns the bus past turnaround and nxt is low
  assign rx_cmd = dir_q_i && bus_i.dir && !bus_i.nxt;

  // End of packet cue for the capture block
  assign rx_active_end_o = rx_cmd && (bus_i.data[5:4] != RXCMD_ACTIVE);

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      line_state_o <= LINE_SE0;
      vbus_valid_o <= 1'b0;
    end else if (rx_cmd) begin
      line_state_o <= bus_i.data[1:0];
      vbus_valid_o <= &bus_i.data[3:2];  // Both VbusValid bits set
    end
  end

endmodule

/* src/ulpi_tx_ctrl.sv */
`timescale 1ns/1ps
module ulpi_tx_ctrl (
  input  logic                   ulpi_clk,
  input  logic                   rst_n,
  input  ulpi_pkg::ulpi_bus_t    bus_i,
  input  logic                   dir_q_i,
  input  logic                   tx_valid_i,
  input  ulpi_pkg::stream_beat_t tx_beat_i,
  output logic                   tx_ready_o,
  output logic [7:0]             data_o,
  output logic                   stp_o,
  output logic                   idle_o
);
  import ulpi_pkg::*;

  link_state_e  state_q;
  link_state_e  snext_q;     // Where LS_STOP goes next
  logic [7:0]   reg_data_q;  // Data byte of the pending register write
  stream_beat_t buf_q;
  logic         buf_valid_q;
  logic         ready_q;
  logic         drive;
  logic         take;
  logic         buf_load;

  assign drive = !dir_q_i && !bus_i.dir;

  // No handshake while the PHY turns the bus around
  assign tx_ready_o = ready_q && !bus_i.dir;
  assign take       = tx_valid_i && tx_ready_o;
  assign buf_load   = drive && (state_q == LS_TX) && !bus_i.nxt && take;
  assign idle_o     = (state_q == LS_IDLE);

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      state_q     <= LS_INIT;
      snext_q     <= LS_IDLE;
      data_o      <= '0;
      stp_o       <= 1'b0;
      ready_q     <= 1'b0;
      buf_valid_q <= 1'b0;
    end else if (!drive) begin
      // PHY owns the bus so the state is frozen
      stp_o       <= 1'b0;
      ready_q     <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      stp_o <= 1'b0;
      case (state_q)
        LS_INIT: begin
          state_q <= LS_WRITE_ADDR;
          snext_q <= LS_WRITE_ADDR;  // FUNC_CTRL write follows
          data_o  <= {CMD_REG_WRITE, REG_OTG_CTRL};
        end
        LS_WRITE_ADDR: begin
          if (bus_i.nxt) begin
            state_q <= LS_WRITE_DATA;
            data_o  <= reg_data_q;
          end
        end
        LS_WRITE_DATA: begin
          if (bus_i.nxt) begin
            state_q <= LS_STOP;
            data_o  <= {CMD_IDLE, 6'h00};
            stp_o   <= 1'b1;
          end
        end
        LS_STOP: begin
          state_q <= snext_q;
          ready_q <= (snext_q == LS_IDLE);
          if (snext_q == LS_WRITE_ADDR) begin
            snext_q <= LS_IDLE;
            data_o  <= {CMD_REG_WRITE, REG_FUNC_CTRL};
          end
        end
        LS_IDLE: begin
          ready_q     <= 1'b1;
          buf_valid_q <= 1'b0;
          if (take) begin
            state_q <= tx_beat_i.last ? LS_TX_LAST : LS_TX;
            data_o  <= {CMD_TX, 2'b00, tx_beat_i.data[3:0]};  // PID in TX cmd
            ready_q <= !tx_beat_i.last;
          end
        end
        LS_TX: begin
          if (bus_i.nxt) begin
            buf_valid_q <= 1'b0;
            if (buf_valid_q) begin
              state_q <= buf_q.last ? LS_TX_LAST : LS_TX;
              data_o  <= buf_q.data;
              ready_q <= !buf_q.last;
            end else if (take) begin
              state_q <= tx_beat_i.last ? LS_TX_LAST : LS_TX;
              data_o  <= tx_beat_i.data;
              ready_q <= !tx_beat_i.last;
            end else begin
              data_o  <= {CMD_IDLE, 6'h00};  // Stream underrun
              ready_q <= 1'b1;
            end
          end else begin
            // Under back-pressure the driven byte stays put
            if (take) begin
              buf_valid_q <= 1'b1;
            end
            ready_q <= !buf_valid_q && !take;
          end
        end
        LS_TX_LAST: begin
          if (bus_i.nxt) begin
            state_q <= LS_STOP;
            snext_q <= LS_IDLE;
            data_o  <= {CMD_IDLE, 6'h00};
            stp_o   <= 1'b1;
            ready_q <= 1'b0;
          end
        end
        default: state_q <= LS_INIT;
      endcase
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (drive && state_q == LS_INIT) begin
      reg_data_q <= OTG_CTRL_INIT;
    end else if (drive && state_q == LS_STOP && snext_q == LS_WRITE_ADDR) begin
      reg_data_q <= FUNC_CTRL_FS;
    end
    if (buf_load) begin
      buf_q <= tx_beat_i;  // Byte that arrived while nxt was low
    end
  end

endmodule

/* tb/tb_ulpi_link.sv */
`timescale 1ns/1ps
module tb_ulpi_link;
  import ulpi_pkg::*;

  logic         ulpi_clk;
  logic         rst_n;
  logic         ulpi_dir_i;
  logic         ulpi_nxt_i;
  logic [7:0]   ulpi_data_i;
  logic [7:0]   ulpi_data_o;
  logic         ulpi_stp_o;
  logic         ulpi_reset_o;
  logic         rx_valid_o;
  stream_beat_t rx_beat_o;
  logic         rx_ready_i;
  logic         tx_valid_i;
  stream_beat_t tx_beat_i;
  logic         tx_ready_o;
  usb_status_t  status_o;
  logic         idle_o;

  logic [7:0]   tdata [0:255];
  logic [7:0]   pkt [0:31];
  logic [31:0]  lfsr;
  logic         phy_busy;   // PHY is inside a link transmit
  logic         timeout_hit;
  int           tx_len;
  int           tx_idx;
  int           ptr;
  int           rec;
  int           kind;
  int           len;
  int           mask;

  ulpi_link uut (.*);

  ulpi_link_checker chk (
    .ulpi_clk   (ulpi_clk),
    .dir_i      (ulpi_dir_i),
    .nxt_i      (ulpi_nxt_i),
    .data_i     (ulpi_data_o),
    .stp_i      (ulpi_stp_o),
    .rx_valid_i (rx_valid_o),
    .rx_beat_i  (rx_beat_o),
    .rx_ready_i (rx_ready_i)
  );

  bind ulpi_tx_ctrl ulpi_link_properties u_props (
    .ulpi_clk   (ulpi_clk),
    .rst_n      (rst_n),
    .bus_i      (bus_i),
    .dir_q_i    (dir_q_i),
    .data_o     (data_o),
    .stp_o      (stp_o),
    .tx_ready_o (tx_ready_o),
    .state_q    (state_q)
  );

  initial ulpi_clk = 1'b0;
  always #5 ulpi_clk = ~ulpi_clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen", what);
    timeout_hit = 1'b1;
  endtask

  // One clock of the PHY nxt model and the TX stream source
  task automatic link_cycle(input logic stall);
    @(posedge ulpi_clk);
    if (ulpi_stp_o) begin
      phy_busy = 1'b0;
      ulpi_nxt_i <= 1'b0;
    end else if (phy_busy || ulpi_data_o != 8'h00) begin
      phy_busy = 1'b1;
      ulpi_nxt_i <= stall ? lfsr_bit() : 1'b1;
    end else begin
      ulpi_nxt_i <= 1'b0;
    end
    if (tx_valid_i && tx_ready_o) begin
      tx_idx++;
    end
    if (tx_idx < tx_len) begin
      tx_valid_i <= 1'b1;
      tx_beat_i  <= '{data: pkt[tx_idx], last: (tx_idx == tx_len - 1)};
    end else begin
      tx_valid_i <= 1'b0;
    end
  endtask

  task automatic wait_tx_ready(input string what);
    int n;
    n = 0;
    while (!tx_ready_o && n < 40) begin
      @(posedge ulpi_clk);
      n++;
    end
    if (!tx_ready_o) begin
      report_timeout(what);
    end
  endtask

  task automatic run_init();
    int n;
    chk.clear_items();
    chk.expect_item({CMD_REG_WRITE, REG_OTG_CTRL, 1'b0});
    chk.expect_item({OTG_CTRL_INIT, 1'b0});
    chk.expect_item({CMD_REG_WRITE, REG_FUNC_CTRL, 1'b0});
    chk.expect_item({FUNC_CTRL_FS, 1'b0});
    n = 0;
    while (!(chk.stop_count >= 2 && idle_o) && n < 300) begin
      link_cycle(1'b1);
      n++;
    end
    if (!(chk.stop_count >= 2 && idle_o)) begin
      report_timeout("idle after the init register writes");
    end else begin
      @(negedge ulpi_clk);
      chk.compare_items("init_writes");
      chk.check_value("init_writes", "stop count", 2, chk.stop_count);
      chk.check_value("init_writes", "ulpi_reset_o", 0, ulpi_reset_o);
      chk.finish_test("init_writes");
    end
  endtask

  task automatic tx_packet(input string name, input logic stall);
    int n;
    int start;
    chk.clear_items();
    chk.expect_item({CMD_TX, 2'b00, pkt[0][3:0], 1'b0});  // PID in the command
    for (int i = 1; i < len; i++) begin
      chk.expect_item({pkt[i], 1'b0});
    end
    tx_len = len;
    tx_idx = 0;
    start  = chk.stop_count;
    n = 0;
    while (!(chk.stop_count > start && idle_o) && n < 300) begin
      link_cycle(stall);
      n++;
    end
    if (!(chk.stop_count > start && idle_o)) begin
      report_timeout("stop and idle after a TX packet");
    end else begin
      @(negedge ulpi_clk);
      chk.compare_items(name);
      chk.check_value(name, "stop count", start + 1, chk.stop_count);
      chk.finish_test(name);
    end
  endtask

  task automatic rx_packet(input string name, input logic ready);
    chk.clear_items();
    for (int i = 0; i < len; i++) begin
      if (ready) begin
        chk.expect_item({pkt[i], (i == len - 1)});
      end
    end
    @(posedge ulpi_clk);
    rx_ready_i  <= ready;
    ulpi_dir_i  <= 1'b1;  // Turnaround with RxActive
    ulpi_nxt_i  <= 1'b1;
    ulpi_data_i <= 8'h00;
    for (int i = 0; i < len; i++) begin
      @(posedge ulpi_clk);
      ulpi_data_i <= pkt[i];
    end
    @(posedge ulpi_clk);
    ulpi_dir_i  <= 1'b0;
    ulpi_nxt_i  <= 1'b0;
    ulpi_data_i <= 8'h00;
    wait_tx_ready("link return after an RX packet");
    if (!timeout_hit) begin
      @(negedge ulpi_clk);
      if (ready) begin
        chk.compare_items(name);
      end
      chk.check_value(name, "rx_overflow", !ready, status_o.rx_overflow);
      if (!ready) begin
        chk.check_value(name, "stp while dir high", 1, chk.stp_dir_count != 0);
      end
      chk.finish_test(name);
    end
  endtask

  task automatic rx_cmds(input string name);
    @(posedge ulpi_clk);
    ulpi_dir_i <= 1'b1;
    ulpi_nxt_i <= 1'b0;
    for (int i = 0; i < len; i++) begin
      @(posedge ulpi_clk);
      ulpi_data_i <= pkt[i];
    end
    @(posedge ulpi_clk);
    ulpi_dir_i  <= 1'b0;
    ulpi_data_i <= 8'h00;
    wait_tx_ready("link return after RX commands");
    if (!timeout_hit) begin
      @(negedge ulpi_clk);
      chk.check_value(name, "line_state", pkt[len - 1][1:0], status_o.line_state);
      chk.check_value(name, "vbus_valid", &pkt[len - 1][3:2], status_o.vbus_valid);
      chk.finish_test(name);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    ulpi_dir_i  = 1'b0;
    ulpi_nxt_i  = 1'b0;
    ulpi_data_i = 8'h00;
    rx_ready_i  = 1'b1;
    tx_valid_i  = 1'b0;
    tx_beat_i   = '0;
    lfsr        = 32'h104b;
    phy_busy    = 1'b0;
    timeout_hit = 1'b0;
    tx_len      = 0;
    tx_idx      = 0;
    $readmemh("tb/ulpi_testdata.txt", tdata);
    repeat (16) @(posedge ulpi_clk);
    chk.check_value("init_writes", "ulpi_reset_o in reset", 1, ulpi_reset_o);
    rst_n <= 1'b1;
    run_init();
    ptr = 0;
    rec = 0;
    while (!timeout_hit && tdata[ptr] != 8'h00) begin
      kind = tdata[ptr];
      len  = tdata[ptr + 1];
      for (int i = 0; i < len; i++) begin
        pkt[i] = tdata[ptr + 2 + i];
      end
      mask = tdata[ptr + 2 + len];
      ptr  = ptr + 3 + len;
      rec++;
      case (kind)
        1: tx_packet($sformatf("%s_%0d", (mask != 0) ? "tx_stall" : "tx_packet", rec),
                     mask != 0);
        2: rx_packet($sformatf("rx_packet_%0d", rec), 1'b1);
        3: rx_cmds($sformatf("rx_cmd_status_%0d", rec));
        4: rx_packet($sformatf("rx_overflow_%0d", rec), 1'b0);
        default: begin
          $display("Unknown record kind %0d in the test data", kind);
          timeout_hit = 1'b1;
        end
      endcase
    end
    @(negedge ulpi_clk);
    chk.report();
    if (timeout_hit || chk.fail_count != 0) begin
      $display("Simulation finished: FAIL");
    end else begin
      $display("Simulation finished: PASS");
    end
    $finish;
  end

endmodule

/* tb/ulpi_link_checker.sv */
`timescale 1ns/1ps
module ulpi_link_checker (
  input logic                   ulpi_clk,
  input logic                   dir_i,
  input logic                   nxt_i,
  input logic [7:0]             data_i,
  input logic                   stp_i,
  input logic                   rx_valid_i,
  input ulpi_pkg::stream_beat_t rx_beat_i,
  input logic                   rx_ready_i
);
  import ulpi_pkg::*;

  logic [8:0] exp_q[$];  // {data, last}
  logic [8:0] got_q[$];
  logic       dir_prev      = 1'b0;
  logic       test_bad      = 1'b0;
  int         stop_count    = 0;
  int         stp_dir_count = 0;
  int         pass_count    = 0;
  int         fail_count    = 0;

  // Sampled at the falling edge where every signal is settled
  always @(negedge ulpi_clk) begin
    if (!dir_i && !dir_prev && nxt_i && !stp_i) begin
      got_q.push_back({data_i, 1'b0});  // Byte taken by the PHY
    end
    if (rx_valid_i && rx_ready_i) begin
      got_q.push_back(rx_beat_i);
    end
    if (stp_i && !dir_i && !dir_prev) begin
      stop_count++;
    end
    if (stp_i && dir_i) begin
      stp_dir_count++;
    end
    dir_prev = dir_i;
  end

  task automatic clear_items();
    exp_q.delete();
    got_q.delete();
    stp_dir_count = 0;
  endtask

  task automatic expect_item(input logic [8:0] item);
    exp_q.push_back(item);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
      test_bad = 1'b1;
    end
  endtask

  task automatic compare_items(input string name);
    int n;
    if (exp_q.size() != got_q.size()) begin
      $display("FAIL %s item count: expected %0d, actual %0d", name, exp_q.size(),
               got_q.size());
      test_bad = 1'b1;
    end
    n = (exp_q.size() < got_q.size()) ? exp_q.size() : got_q.size();
    for (int i = 0; i < n; i++) begin
      if (exp_q[i] !== got_q[i]) begin
        $display("FAIL %s item %0d: expected %h, actual %h", name, i, exp_q[i], got_q[i]);
        test_bad = 1'b1;
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (test_bad) begin
      fail_count++;
      $display("test %s: failed", name);
    end else begin
      pass_count++;
      $display("test %s: passed", name);
    end
    test_bad = 1'b0;
  endtask

  task automatic report();
    $display("Tests run: %0d, passed: %0d, failed: %0d", pass_count + fail_count,
             pass_count, fail_count);
  endtask

endmodule

/* tb/ulpi_link_properties.sv */
`timescale 1ns/1ps
module ulpi_link_properties (
  input logic                     ulpi_clk,
  input logic                     rst_n,
  input ulpi_pkg::ulpi_bus_t      bus_i,
  input logic                     dir_q_i,
  input logic [7:0]               data_o,
  input logic                     stp_o,
  input logic                     tx_ready_o,
  input ulpi_pkg::link_state_e    state_q
);
  import ulpi_pkg::*;

  logic drive;
  logic hold_state;

  assign drive      = !dir_q_i && !bus_i.dir;
  // States where the driven byte waits for nxt
  assign hold_state = (state_q != LS_IDLE) && (state_q != LS_INIT) && (state_q != LS_STOP);

  stp_single: assert property (@(posedge ulpi_clk) disable iff (!rst_n)
    (stp_o && !bus_i.dir) |=> !(stp_o && !bus_i.dir))
    else $error("stp held high for two cycles while the link drives");

  data_hold: assert property (@(posedge ulpi_clk) disable iff (!rst_n)
    (drive && !bus_i.nxt && hold_state) |=> $stable(data_o))
    else $error("driven byte changed without nxt");

  ready_turn: assert property (@(posedge ulpi_clk) disable iff (!rst_n)
    dir_q_i |-> !tx_ready_o)
    else $error("tx_ready high while the PHY owns the bus");

endmodule

/* tb/ulpi_testdata.txt */
// kind len bytes... stall: kind 01 TX, 02 RX, 03 RX commands, 04 RX with ready low
// stall 01 gives random nxt stalls, a kind of 00 ends the list
01 04 C3 11 22 33 00
01 04 C3 11 22 33 01
01 01 D2 01
01 03 4B 00 7E 01
02 05 C3 A5 5A 00 FF 00
03 02 0D 06 00
03 01 0F 00
04 03 4B 01 02 00
00

/* ulpi_link.f */
src/ulpi_pkg.sv
src/ulpi_rx_cmd.sv
src/ulpi_rx_capture.sv
src/ulpi_tx_ctrl.sv
src/ulpi_link.sv
tb/ulpi_link_properties.sv
tb/ulpi_link_checker.sv
tb/tb_ulpi_link.sv
